// File: verilog.f
src/pdes_event_pkg.sv
src/sched_pkg.sv
src/event_queue.sv
src/rr_arbiter.sv
src/run_control.sv
src/core_tracker.sv
src/gvt_unit.sv
src/event_stats.sv
src/phold_scheduler.sv
verification/tb_clock_gen.sv
verification/phold_scheduler_tb.sv

// File: verification/phold_scheduler_tb.sv
`timescale 1ns/1ns

module phold_scheduler_tb;

   localparam int NUM_CORE = sched_pkg::NUM_CORE;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_INIT = 6;
   localparam int SIM_END = 200;
   localparam int NULL_AFTER = 180;
   localparam pdes_event_pkg::lp_id_t LP_MASK = 8'h07;
   localparam sched_pkg::core_vec_t CORE_MASK = 4'b1011;
   // about 20 cycles per unit of simulated time, plus init and reset
   localparam int WATCHDOG_CYCLES = SIM_END * 20 + 2 * NUM_INIT + RESET_CYCLES + 4;

   // core model phases
   localparam logic [1:0] PH_IDLE = 2'd0;
   localparam logic [1:0] PH_WORK = 2'd1;
   localparam logic [1:0] PH_OFFER = 2'd2;
   localparam logic [1:0] PH_COOL = 2'd3;

   logic clk;
   logic rst_n = 1'b0;
   pdes_event_pkg::time_t sim_end = '0;
   sched_pkg::init_cnt_t num_init_events = '0;
   pdes_event_pkg::lp_id_t lp_mask = '0;
   sched_pkg::core_vec_t core_mask = '0;
   sched_pkg::core_vec_t core_ready = '1;
   sched_pkg::core_vec_t new_vld = '0;
   pdes_event_pkg::event_msg_t [NUM_CORE-1:0] new_msg = '0;
   logic disp_vld;
   sched_pkg::core_id_t disp_core;
   pdes_event_pkg::event_msg_t disp_msg;
   sched_pkg::core_vec_t new_ack;
   pdes_event_pkg::time_t gvt;
   logic rtn_vld;
   logic cleanup;
   sched_pkg::stat_cnt_t total_cycles;
   sched_pkg::stat_cnt_t total_events;
   sched_pkg::stat_cnt_t total_antimsg;

   int seed = 87;
   int err_count = 0;
   int disp_count = 0;
   int anti_count = 0;
   int cleanup_count = 0;
   int cycle_count = 0;
   logic [1:0] phase [NUM_CORE] = '{default: PH_IDLE};
   int wait_cnt [NUM_CORE] = '{default: 0};
   pdes_event_pkg::time_t held_ts [NUM_CORE] = '{default: '0};
   sched_pkg::core_vec_t holding = '0;
   pdes_event_pkg::time_t held_min;

   // what the last rising edge carried
   logic disp_seen;
   sched_pkg::core_id_t disp_core_q;
   pdes_event_pkg::event_msg_t disp_msg_q;
   sched_pkg::core_vec_t ack_q;
   pdes_event_pkg::time_t gvt_prev;
   logic rtn_prev = 1'b0;

   tb_clock_gen #(.PERIOD(100)) u_clk (.clk(clk));

   phold_scheduler dut0 (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .core_mask       (core_mask),
      .core_ready      (core_ready),
      .disp_vld        (disp_vld),
      .disp_core       (disp_core),
      .disp_msg        (disp_msg),
      .new_vld         (new_vld),
      .new_msg         (new_msg),
      .new_ack         (new_ack),
      .gvt             (gvt),
      .rtn_vld         (rtn_vld),
      .cleanup         (cleanup),
      .total_cycles    (total_cycles),
      .total_events    (total_events),
      .total_antimsg   (total_antimsg)
   );

   function automatic int rand_range(int n);
      return 1 + ({$random(seed)} % n);
   endfunction

   // initial event idx: time 0, no cancel, lp from the index
   function automatic pdes_event_pkg::event_msg_t init_event(int idx);
      pdes_event_pkg::event_msg_t msg;
      msg.cancel = 1'b0;
      msg.lp = pdes_event_pkg::lp_id_t'(idx) & LP_MASK;
      msg.ts = '0;
      return msg;
   endfunction

   // next PHOLD event, a null message only late in the run
   function automatic pdes_event_pkg::event_msg_t make_new_event(pdes_event_pkg::time_t held);
      pdes_event_pkg::event_msg_t msg;
      msg.ts = held + pdes_event_pkg::time_t'(rand_range(20));
      msg.lp = pdes_event_pkg::lp_id_t'($random(seed)) & LP_MASK;
      msg.cancel = (rand_range(8) == 1);
      if (gvt > NULL_AFTER && held > SIM_END && rand_range(4) == 1) begin
         msg = '0;
         msg.cancel = 1'b1;
      end
      return msg;
   endfunction

   task automatic finish_run();
      $display("dispatches %0d, anti-messages %0d, errors %0d",
               disp_count, anti_count, err_count);
      if (err_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   endtask

   always @(posedge clk) begin
      disp_seen <= disp_vld;
      disp_core_q <= disp_core;
      disp_msg_q <= disp_msg;
      ack_q <= new_ack;
      gvt_prev <= gvt;
      rtn_prev <= rtn_vld;
      if (rst_n) cycle_count <= cycle_count + 1;
      if (rst_n && disp_vld) begin
         disp_count <= disp_count + 1;
         if (disp_msg.cancel) anti_count <= anti_count + 1;
      end
      if (rst_n && cleanup) cleanup_count <= cleanup_count + 1;
   end

   // core models, one phase machine per core
   always @(negedge clk) begin
      if (rst_n) begin
         for (int c = 0; c < NUM_CORE; c++) begin
            case (phase[c])
               PH_IDLE: begin
                  if (disp_seen && int'(disp_core_q) == c) begin
                     core_ready[c] = 1'b0;
                     holding[c] = 1'b1;
                     held_ts[c] = disp_msg_q.ts;
                     wait_cnt[c] = rand_range(8);
                     phase[c] = PH_WORK;
                  end
               end
               PH_WORK: begin
                  wait_cnt[c] = wait_cnt[c] - 1;
                  if (wait_cnt[c] == 0) begin
                     new_msg[c] = make_new_event(held_ts[c]);
                     new_vld[c] = 1'b1;
                     phase[c] = PH_OFFER;
                  end
               end
               PH_OFFER: begin
                  if (ack_q[c]) begin
                     new_vld[c] = 1'b0;
                     wait_cnt[c] = rand_range(4);
                     phase[c] = PH_COOL;
                  end
               end
               default: begin
                  wait_cnt[c] = wait_cnt[c] - 1;
                  if (wait_cnt[c] == 0) begin
                     core_ready[c] = 1'b1;
                     holding[c] = 1'b0;
                     phase[c] = PH_IDLE;
                  end
               end
            endcase
         end
      end
   end

   always_comb begin
      held_min = pdes_event_pkg::TIME_MAX;
      for (int c = 0; c < NUM_CORE; c++) begin
         if (holding[c] && held_ts[c] < held_min) held_min = held_ts[c];
      end
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      disp_vld && disp_count < NUM_INIT |-> disp_msg == init_event(disp_count))
   else begin
      err_count++;
      $display("Error at %0t: disp_msg = %h, expected %h", $time,
               $sampled(disp_msg), init_event($sampled(disp_count)));
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      disp_vld |-> core_ready[disp_core] && CORE_MASK[disp_core])
   else begin
      err_count++;
      $display("Error at %0t: disp_core = %0d, expected one of ready %b masked by %b",
               $time, $sampled(disp_core), $sampled(core_ready), CORE_MASK);
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      disp_vld |-> disp_msg.ts >= gvt)
   else begin
      err_count++;
      $display("Error at %0t: disp_msg.ts = %0d, expected at least gvt %0d", $time,
               $sampled(disp_msg.ts), $sampled(gvt));
   end

   // a null message must never reach a core
   assert property (@(posedge clk) disable iff (!rst_n)
      disp_vld |-> !(disp_msg.cancel && disp_msg.lp == '0 && disp_msg.ts == '0))
   else begin
      err_count++;
      $display("Null message dispatched at %0t", $time);
   end

   // one ack at a time, only to a core that offers
   assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(new_ack) && (new_ack & ~new_vld) == '0)
   else begin
      err_count++;
      $display("Error at %0t: new_ack = %b, expected at most one bit of new_vld %b",
               $time, $sampled(new_ack), $sampled(new_vld));
   end

   assert property (@(posedge clk) disable iff (!rst_n) gvt >= gvt_prev)
   else begin
      err_count++;
      $display("Error at %0t: gvt = %0d, expected at least %0d", $time,
               $sampled(gvt), $sampled(gvt_prev));
   end

   assert property (@(posedge clk) disable iff (!rst_n) gvt <= held_min)
   else begin
      err_count++;
      $display("Error at %0t: gvt = %0d, expected at most %0d", $time,
               $sampled(gvt), $sampled(held_min));
   end

   assert property (@(posedge clk) disable iff (!rst_n) rtn_prev |-> rtn_vld)
   else begin
      err_count++;
      $display("rtn_vld dropped after rising at %0t", $time);
   end

   assert property (@(posedge clk) disable iff (!rst_n) rtn_vld |-> !disp_vld)
   else begin
      err_count++;
      $display("Dispatch after run complete at %0t", $time);
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      cleanup |-> cleanup_count == 0)
   else begin
      err_count++;
      $display("Extra or stretched cleanup pulse at %0t", $time);
   end

   assert property (@(posedge clk) disable iff (!rst_n) cleanup |-> core_ready == '1)
   else begin
      err_count++;
      $display("Error at %0t: core_ready = %b, expected %b", $time,
               $sampled(core_ready), 4'b1111);
   end

   // idle, init and ready come before running, finished after it
   assert property (@(posedge clk) disable iff (!rst_n)
      cleanup |-> total_cycles == cycle_count - (2 * NUM_INIT + 3))
   else begin
      err_count++;
      $display("Error at %0t: total_cycles = %0d, expected %0d", $time,
               $sampled(total_cycles), $sampled(cycle_count) - (2 * NUM_INIT + 3));
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      cleanup |-> total_events == disp_count)
   else begin
      err_count++;
      $display("Error at %0t: total_events = %0d, expected %0d", $time,
               $sampled(total_events), $sampled(disp_count));
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      cleanup |-> total_antimsg == anti_count)
   else begin
      err_count++;
      $display("Error at %0t: total_antimsg = %0d, expected %0d", $time,
               $sampled(total_antimsg), $sampled(anti_count));
   end

   initial begin
      sim_end = pdes_event_pkg::time_t'(SIM_END);
      num_init_events = sched_pkg::init_cnt_t'(NUM_INIT);
      lp_mask = LP_MASK;
      core_mask = CORE_MASK;
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      while (!cleanup) @(negedge clk);
      // a few more cycles to catch a second cleanup
      repeat (4) @(negedge clk);
      finish_run();
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      err_count++;
      $display("Timeout: no cleanup after %0d cycles", WATCHDOG_CYCLES);
      finish_run();
   end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD = 100
) (
   output logic clk
);

   // free running, first rising edge half a period in
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

// File: src/phold_scheduler.sv
`timescale 1ns/1ns

module phold_scheduler (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  pdes_event_pkg::time_t                                 sim_end,
   input  sched_pkg::init_cnt_t                                  num_init_events,
   input  pdes_event_pkg::lp_id_t                                lp_mask,
   input  sched_pkg::core_vec_t                                  core_mask,
   input  sched_pkg::core_vec_t                                  core_ready,
   output logic                                                  disp_vld,
   output sched_pkg::core_id_t                                   disp_core,
   output pdes_event_pkg::event_msg_t                            disp_msg,
   input  sched_pkg::core_vec_t                                  new_vld,
   input  pdes_event_pkg::event_msg_t [sched_pkg::NUM_CORE-1:0] new_msg,
   output sched_pkg::core_vec_t                                  new_ack,
   output pdes_event_pkg::time_t                                 gvt,
   output logic                                                  rtn_vld,
   output logic                                                  cleanup,
   output sched_pkg::stat_cnt_t                                  total_cycles,
   output sched_pkg::stat_cnt_t                                  total_events,
   output sched_pkg::stat_cnt_t                                  total_antimsg
);

   logic q_busy;
   logic enq;
   logic deq;
   logic q_enq;
   logic ack_en;
   logic q_full;
   logic q_empty;
   pdes_event_pkg::event_msg_t enq_msg;
   pdes_event_pkg::event_msg_t head_msg;
   pdes_event_pkg::event_msg_t init_msg;
   logic init_enq;
   logic running;
   logic dispatch_en;
   sched_pkg::core_vec_t send_req;
   logic rcv_vld;
   logic send_vld;
   sched_pkg::core_id_t rcv_id;
   sched_pkg::core_id_t send_id;
   pdes_event_pkg::time_t core_min;
   logic cores_idle;

   assign send_req = core_ready & core_mask;

   // enqueue has priority, and every queue operation costs a busy cycle
   assign ack_en = !q_busy && running && !q_full && rcv_vld;
   assign enq = (!q_busy && init_enq) || ack_en;
   assign deq = !q_busy && !enq && dispatch_en && !q_empty && send_vld;

   assign enq_msg = init_enq ? init_msg : new_msg[rcv_id];
   assign q_enq = enq && (enq_msg != pdes_event_pkg::NULL_MSG);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_busy <= 1'b0;
      end else begin
         q_busy <= enq || deq;
      end
   end

   assign disp_vld = deq;
   assign disp_core = send_id;
   assign disp_msg = head_msg;
   assign new_ack = ack_en ? (sched_pkg::core_vec_t'(1) << rcv_id) : '0;

   event_queue u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (q_enq),
      .deq      (deq),
      .enq_msg  (enq_msg),
      .head_msg (head_msg),
      .full     (q_full),
      .empty    (q_empty)
   );

   // new events coming back from the cores
   rr_arbiter rcv_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (new_vld),
      .take      (ack_en),
      .grant_vld (rcv_vld),
      .grant_id  (rcv_id)
   );

   // idle cores waiting for work
   rr_arbiter send_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (send_req),
      .take      (deq),
      .grant_vld (send_vld),
      .grant_id  (send_id)
   );

   run_control u_run_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .gvt             (gvt),
      .sim_end         (sim_end),
      .cores_idle      (cores_idle),
      .q_full          (q_full),
      .init_enq        (init_enq),
      .init_msg        (init_msg),
      .running         (running),
      .dispatch_en     (dispatch_en),
      .rtn_vld         (rtn_vld),
      .cleanup         (cleanup)
   );

   core_tracker u_tracker (
      .clk        (clk),
      .rst_n      (rst_n),
      .disp_vld   (deq),
      .disp_core  (send_id),
      .disp_time  (head_msg.ts),
      .core_ready (core_ready),
      .min_time   (core_min),
      .cores_idle (cores_idle)
   );

   gvt_unit u_gvt (
      .clk       (clk),
      .rst_n     (rst_n),
      .running   (running),
      .q_empty   (q_empty),
      .head_time (head_msg.ts),
      .core_min  (core_min),
      .gvt       (gvt)
   );

   event_stats u_stats (
      .clk           (clk),
      .rst_n         (rst_n),
      .running       (running),
      .disp_vld      (deq),
      .disp_cancel   (head_msg.cancel),
      .total_cycles  (total_cycles),
      .total_events  (total_events),
      .total_antimsg (total_antimsg)
   );

endmodule

// File: src/event_stats.sv
`timescale 1ns/1ns

module event_stats (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 running,
   input  logic                 disp_vld,
   input  logic                 disp_cancel,
   output sched_pkg::stat_cnt_t total_cycles,
   output sched_pkg::stat_cnt_t total_events,
   output sched_pkg::stat_cnt_t total_antimsg
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_cycles <= '0;
         total_events <= '0;
         total_antimsg <= '0;
      end else begin
         if (running) total_cycles <= total_cycles + 1'b1;
         if (disp_vld) total_events <= total_events + 1'b1;
         // anti-messages also count as events
         if (disp_vld && disp_cancel) total_antimsg <= total_antimsg + 1'b1;
      end
   end

endmodule

// File: src/gvt_unit.sv
`timescale 1ns/1ns

module gvt_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  running,
   input  logic                  q_empty,
   input  pdes_event_pkg::time_t head_time,
   input  pdes_event_pkg::time_t core_min,
   output pdes_event_pkg::time_t gvt
);

   pdes_event_pkg::time_t q_min;
   pdes_event_pkg::time_t gvt_nxt;

   assign q_min = q_empty ? pdes_event_pkg::TIME_MAX : head_time;
   assign gvt_nxt = (q_min < core_min) ? q_min : core_min;

   // nothing pending anywhere, keep the last bound
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (running && gvt_nxt != pdes_event_pkg::TIME_MAX) begin
         gvt <= gvt_nxt;
      end
   end

endmodule

// File: src/core_tracker.sv
`timescale 1ns/1ns

module core_tracker (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  disp_vld,
   input  sched_pkg::core_id_t   disp_core,
   input  pdes_event_pkg::time_t disp_time,
   input  sched_pkg::core_vec_t  core_ready,
   output pdes_event_pkg::time_t min_time,
   output logic                  cores_idle
);

   sched_pkg::core_vec_t active;
   pdes_event_pkg::time_t held [sched_pkg::NUM_CORE];

   // a dispatch wins over the ready level still seen in that cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active <= '0;
      end else begin
         for (int c = 0; c < sched_pkg::NUM_CORE; c++) begin
            if (disp_vld && disp_core == sched_pkg::core_id_t'(c)) begin
               active[c] <= 1'b1;
            end else if (core_ready[c]) begin
               active[c] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (disp_vld) held[disp_core] <= disp_time;
   end

   always_comb begin
      min_time = pdes_event_pkg::TIME_MAX;
      for (int c = 0; c < sched_pkg::NUM_CORE; c++) begin
         if (active[c] && held[c] < min_time) min_time = held[c];
      end
   end

   assign cores_idle = ~|active;

endmodule

// File: src/run_control.sv
`timescale 1ns/1ns

module run_control (
   input  logic                       clk,
   input  logic                       rst_n,
   input  sched_pkg::init_cnt_t       num_init_events,
   input  pdes_event_pkg::lp_id_t     lp_mask,
   input  pdes_event_pkg::time_t      gvt,
   input  pdes_event_pkg::time_t      sim_end,
   input  logic                       cores_idle,
   input  logic                       q_full,
   output logic                       init_enq,
   output pdes_event_pkg::event_msg_t init_msg,
   output logic                       running,
   output logic                       dispatch_en,
   output logic                       rtn_vld,
   output logic                       cleanup
);

   sched_pkg::run_state_t state;
   sched_pkg::run_state_t state_nxt;
   logic [4:0] init_cnt;
   logic [4:0] init_end;
   logic init_done;
   logic end_reached;
   logic rtn_nxt;
   logic cleanup_nxt;

   // one initial event every second cycle
   assign init_end = {num_init_events, 1'b0};
   assign init_done = (init_cnt + 5'd1) >= init_end;
   assign end_reached = gvt > sim_end;

   always_comb begin
      state_nxt = state;
      rtn_nxt = rtn_vld;
      cleanup_nxt = 1'b0;
      case (state)
         sched_pkg::S_IDLE: begin
            // a finished run stays parked until reset
            if (!rtn_vld) state_nxt = sched_pkg::S_INIT;
         end
         sched_pkg::S_INIT: begin
            if (init_done) state_nxt = sched_pkg::S_READY;
         end
         sched_pkg::S_READY: begin
            state_nxt = sched_pkg::S_RUNNING;
         end
         sched_pkg::S_RUNNING: begin
            if (end_reached) begin
               rtn_nxt = 1'b1;
               if (cores_idle) state_nxt = sched_pkg::S_FINISHED;
            end
         end
         sched_pkg::S_FINISHED: begin
            state_nxt = sched_pkg::S_IDLE;
            rtn_nxt = 1'b1;
            cleanup_nxt = 1'b1;
         end
         default: begin
            state_nxt = sched_pkg::S_IDLE;
         end
      endcase
   end

   // queue overflow aborts the run
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= sched_pkg::S_IDLE;
         init_cnt <= '0;
         rtn_vld <= 1'b0;
         cleanup <= 1'b0;
      end else begin
         state <= state_nxt;
         init_cnt <= (state == sched_pkg::S_INIT) ? init_cnt + 5'd1 : 5'd0;
         rtn_vld <= rtn_nxt || q_full;
         cleanup <= cleanup_nxt || q_full;
      end
   end

   assign init_enq = (state == sched_pkg::S_INIT) && !init_cnt[0] && (init_cnt < init_end);
   assign init_msg = '{cancel: 1'b0,
                       lp: lp_mask & pdes_event_pkg::lp_id_t'(init_cnt[4:1]),
                       ts: '0};

   assign running = (state == sched_pkg::S_RUNNING);
   assign dispatch_en = running && !end_reached && !rtn_vld;

endmodule

// File: src/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter (
   input  logic                 clk,
   input  logic                 rst_n,
   input  sched_pkg::core_vec_t req,
   input  logic                 take,
   output logic                 grant_vld,
   output sched_pkg::core_id_t  grant_id
);

   sched_pkg::core_id_t ptr;

   // search downward so the requester closest to ptr wins
   always_comb begin
      int idx;
      grant_vld = 1'b0;
      grant_id = ptr;
      for (int i = sched_pkg::NUM_CORE - 1; i >= 0; i--) begin
         idx = (int'(ptr) + i) % sched_pkg::NUM_CORE;
         if (req[idx]) begin
            grant_vld = 1'b1;
            grant_id = sched_pkg::core_id_t'(idx);
         end
      end
   end

   // pointer wraps to core 0 past the last core
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (take && grant_vld) begin
         ptr <= grant_id + 1'b1;
      end
   end

endmodule

// File: src/event_queue.sv
`timescale 1ns/1ns

module event_queue (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       enq,
   input  logic                       deq,
   input  pdes_event_pkg::event_msg_t enq_msg,
   output pdes_event_pkg::event_msg_t head_msg,
   output logic                       full,
   output logic                       empty
);

   pdes_event_pkg::event_msg_t slots [sched_pkg::Q_DEPTH];
   logic [sched_pkg::NB_QCNT-1:0] cnt;
   logic [sched_pkg::Q_DEPTH-1:0] goes_before;

   // earlier time first, anti-message first on a tie
   function automatic logic ahead_of(pdes_event_pkg::event_msg_t a,
                                     pdes_event_pkg::event_msg_t b);
      return (a.ts < b.ts) || ((a.ts == b.ts) && a.cancel && !b.cancel);
   endfunction

   // empty slots count as behind the new event, so the flags stay monotone
   always_comb begin
      for (int j = 0; j < sched_pkg::Q_DEPTH; j++) begin
         goes_before[j] = (j >= int'(cnt)) || ahead_of(enq_msg, slots[j]);
      end
   end

   always_ff @(posedge clk) begin
      if (enq && !full) begin
         if (goes_before[0]) begin
            slots[0] <= enq_msg;
         end
         for (int j = 1; j < sched_pkg::Q_DEPTH; j++) begin
            if (goes_before[j]) begin
               slots[j] <= goes_before[j-1] ? slots[j-1] : enq_msg;
            end
         end
      end else if (deq && !empty) begin
         for (int j = 0; j < sched_pkg::Q_DEPTH - 1; j++) begin
            slots[j] <= slots[j+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (enq && !full) begin
         cnt <= cnt + 1'b1;
      end else if (deq && !empty) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign head_msg = slots[0];
   assign full = (cnt == sched_pkg::NB_QCNT'(sched_pkg::Q_DEPTH));
   assign empty = (cnt == '0);

endmodule

// File: src/sched_pkg.sv
package sched_pkg;

   localparam int NUM_CORE = 4;
   localparam int NB_COREID = 2;

   typedef logic [NB_COREID-1:0] core_id_t;
   typedef logic [NUM_CORE-1:0] core_vec_t;

   // pending event storage
   localparam int Q_DEPTH = 16;
   localparam int NB_QCNT = 5;

   typedef logic [3:0] init_cnt_t;
   typedef logic [31:0] stat_cnt_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_INIT,
      S_READY,
      S_RUNNING,
      S_FINISHED
   } run_state_t;

endpackage

// File: src/pdes_event_pkg.sv
package pdes_event_pkg;

   localparam int TIME_WID = 16;
   localparam int NB_LPID = 8;

   typedef logic [TIME_WID-1:0] time_t;
   typedef logic [NB_LPID-1:0] lp_id_t;

   // cancel set marks an anti-message
   typedef struct packed {
      logic   cancel;
      lp_id_t lp;
      time_t  ts;
   } event_msg_t;

   // marker for "no value" in minimum searches
   localparam time_t TIME_MAX = '1;

   // "no new event" from a core, acked but never queued
   localparam event_msg_t NULL_MSG = '{cancel: 1'b1, lp: '0, ts: '0};

endpackage
